// File: design/interpPkg.sv
package interpPkg;

    typedef logic signed [17:0] sampleT;   // Q1.17 baseband sample
    typedef logic signed [47:0] cicWordT;
    typedef logic [17:0]        mantissaT; // unsigned Q1.17
    typedef logic [4:0]         exponentT;
    typedef logic [11:0]        busAddrT;  // host word address
    typedef logic [31:0]        busDataT;

    typedef struct packed {
        logic     bypass;
        logic     test;
        logic     invert;
        sampleT   testValue;
        exponentT exponent;
        mantissaT mantissa;
    } ctrlT;

    // host register map
    localparam busAddrT ctrlAddr = 12'd0;
    localparam busAddrT testAddr = 12'd1;
    localparam busAddrT gainAddr = 12'd2;

    // bits outside each mask are not implemented and read as zero
    localparam busDataT ctrlMask = 32'h0000_0007;
    localparam busDataT testMask = 32'h0003_ffff;
    localparam busDataT gainMask = 32'h1f03_ffff;

    localparam int cicOrder   = 3;
    localparam int interpRate = 4;
    // DC gain for a zero-stuffed input is the rate to the power order - 1
    localparam int cicGrowth  = interpRate ** (cicOrder - 1);

    typedef enum logic {
        idle,
        run
    } compStateT;

endpackage

// File: design/interpRegs.sv
`timescale 1ns/1ps

module interpRegs (
    input  logic               clk,
    input  logic               reset,
    input  logic               cs,
    input  interpPkg::busAddrT addr,
    input  interpPkg::busDataT din,
    input  logic               wr0,
    input  logic               wr1,
    input  logic               wr2,
    input  logic               wr3,
    output interpPkg::busDataT dout,
    output interpPkg::ctrlT    ctrl
);

    interpPkg::busDataT ctrlWord;
    interpPkg::busDataT testWord;
    interpPkg::busDataT gainWord;
    logic [3:0]         laneWe;

    function automatic interpPkg::busDataT laneWrite(
        input interpPkg::busDataT old,
        input interpPkg::busDataT data,
        input logic [3:0]         lanes,
        input interpPkg::busDataT mask
    );
        interpPkg::busDataT merged;
        merged = old;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged & mask;
    endfunction

    assign laneWe = cs ? {wr3, wr2, wr1, wr0} : 4'b0000;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlWord <= '0;
            testWord <= '0;
            gainWord <= '0;
        end else if (|laneWe) begin
            case (addr)
                interpPkg::ctrlAddr: ctrlWord <= laneWrite(ctrlWord, din, laneWe, interpPkg::ctrlMask);
                interpPkg::testAddr: testWord <= laneWrite(testWord, din, laneWe, interpPkg::testMask);
                interpPkg::gainAddr: gainWord <= laneWrite(gainWord, din, laneWe, interpPkg::gainMask);
                default: ;                          // writes to unmapped words are dropped
            endcase
        end
    end

    always_comb begin
        dout = '0;
        if (cs) begin
            case (addr)
                interpPkg::ctrlAddr: dout = ctrlWord;
                interpPkg::testAddr: dout = testWord;
                interpPkg::gainAddr: dout = gainWord;
                default:             dout = '0;
            endcase
        end
    end

    always_comb begin
        ctrl.bypass    = ctrlWord[0];
        ctrl.test      = ctrlWord[1];
        ctrl.invert    = ctrlWord[2];
        ctrl.testValue = testWord[17:0];
        ctrl.exponent  = gainWord[28:24];
        ctrl.mantissa  = gainWord[17:0];
    end

endmodule

// File: design/cicComp.sv
`timescale 1ns/1ps

module cicComp (
    input  logic              clk,
    input  logic              reset,
    input  logic              clkEn,
    input  interpPkg::sampleT compIn,
    output interpPkg::sampleT compOut
);

    interpPkg::sampleT    taps [3];       // taps[0] is the newest sample
    interpPkg::compStateT state;
    logic [1:0]           fillCnt;
    logic signed [22:0]   centre;
    logic signed [22:0]   firSum;         // eight times the filter output

    // -1/8, 5/4, -1/8 scaled by eight so only shifts and adds are needed
    always_comb begin
        centre = taps[1];
        firSum = (centre <<< 3) + (centre <<< 1) - taps[0] - taps[2];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            taps[0] <= '0;
            taps[1] <= '0;
            taps[2] <= '0;
            state   <= interpPkg::idle;
            fillCnt <= '0;
            compOut <= '0;
        end else if (clkEn) begin
            taps[0] <= compIn;
            taps[1] <= taps[0];
            taps[2] <= taps[1];
            case (state)
                interpPkg::idle: begin
                    compOut <= '0;
                    fillCnt <= fillCnt + 2'd1;
                    if (fillCnt == 2'd2) begin
                        state <= interpPkg::run;  // third sample lands in the line now
                    end
                end
                interpPkg::run: begin
                    compOut <= firSum[20:3];
                end
                default: begin
                    state <= interpPkg::idle;
                end
            endcase
        end
    end

endmodule

// File: design/cicInterpolate.sv
`timescale 1ns/1ps

module cicInterpolate (
    input  logic               clk,
    input  logic               reset,
    input  logic               clkEn,
    input  interpPkg::sampleT  dIn,
    output interpPkg::cicWordT dOut
);

    interpPkg::cicWordT combDly [interpPkg::cicOrder];
    interpPkg::cicWordT combVal [interpPkg::cicOrder + 1];
    interpPkg::cicWordT stuffed;
    interpPkg::cicWordT integ [interpPkg::cicOrder];

    // comb chain is combinational between the input-rate delay registers
    always_comb begin
        combVal[0] = interpPkg::cicWordT'(dIn);
        for (int i = 0; i < interpPkg::cicOrder; i++) begin
            combVal[i+1] = combVal[i] - combDly[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < interpPkg::cicOrder; i++) begin
                combDly[i] <= '0;
            end
        end else if (clkEn) begin
            for (int i = 0; i < interpPkg::cicOrder; i++) begin
                combDly[i] <= combVal[i];
            end
        end
    end

    // zero stuffing up to the clock rate
    always_ff @(posedge clk) begin
        if (reset) begin
            stuffed <= '0;
        end else begin
            stuffed <= clkEn ? combVal[interpPkg::cicOrder] : '0;
        end
    end

    // integrators run every clock; the word is wide enough that wrap never happens
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < interpPkg::cicOrder; i++) begin
                integ[i] <= '0;
            end
        end else begin
            integ[0] <= integ[0] + stuffed;
            for (int i = 1; i < interpPkg::cicOrder; i++) begin
                integ[i] <= integ[i] + integ[i-1];
            end
        end
    end

    assign dOut = integ[interpPkg::cicOrder - 1];

endmodule

// File: design/gainScale.sv
`timescale 1ns/1ps

module gainScale (
    input  logic                clk,
    input  logic                reset,
    input  interpPkg::cicWordT  dIn,
    input  interpPkg::exponentT exponent,
    input  interpPkg::mantissaT mantissa,
    output interpPkg::sampleT   dOut
);

    interpPkg::sampleT  window;
    logic signed [36:0] product;

    always_ff @(posedge clk) begin
        if (reset) begin
            window  <= '0;
            product <= '0;
        end else begin
            // arithmetic shift keeps the sign when the window runs past bit 47
            window  <= interpPkg::sampleT'(dIn >>> exponent);
            product <= window * $signed({1'b0, mantissa});
        end
    end

    assign dOut = product[34:17];             // back to Q1.17 after the Q1.17 mantissa

endmodule

// File: design/interpolate.sv
`timescale 1ns/1ps

module interpolate (
    input  logic               clk,
    input  logic               reset,
    input  logic               clkEn,
    input  logic               cs,
    input  logic               wr0,
    input  logic               wr1,
    input  logic               wr2,
    input  logic               wr3,
    input  interpPkg::busAddrT addr,
    input  interpPkg::busDataT din,
    output interpPkg::busDataT dout,
    input  interpPkg::sampleT  dataIn,
    output interpPkg::sampleT  dataOut
);

    interpPkg::ctrlT    ctrl;
    interpPkg::sampleT  compOut;
    interpPkg::cicWordT cicOut;
    interpPkg::sampleT  scaled;
    logic [1:0]         bypassHist;           // bit 0 is the newest clkEn sample
    logic               cicClear;
    logic               cicReset;

    interpRegs regs (
        .clk(clk), .reset(reset),
        .cs(cs), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .dout(dout),
        .ctrl(ctrl)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            bypassHist <= '0;
            cicClear   <= 1'b0;
        end else if (clkEn) begin
            bypassHist <= {bypassHist[0], ctrl.bypass};
            cicClear   <= bypassHist[1] & ~bypassHist[0];  // held for one input period
        end
    end

    assign cicReset = reset | cicClear;

    cicComp comp (
        .clk(clk), .reset(reset), .clkEn(clkEn),
        .compIn(dataIn),
        .compOut(compOut)
    );

    cicInterpolate cic (
        .clk(clk), .reset(cicReset), .clkEn(clkEn),
        .dIn(compOut),
        .dOut(cicOut)
    );

    gainScale gain (
        .clk(clk), .reset(reset),
        .dIn(cicOut),
        .exponent(ctrl.exponent),
        .mantissa(ctrl.mantissa),
        .dOut(scaled)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dataOut <= '0;
        end else if (ctrl.test) begin
            dataOut <= ctrl.testValue;
        end else if (ctrl.bypass) begin
            if (clkEn) begin
                dataOut <= ctrl.invert ? -dataIn : dataIn;
            end
        end else begin
            dataOut <= ctrl.invert ? -scaled : scaled;
        end
    end

endmodule

// File: test/interpolate_props.sv
`timescale 1ns/1ps

module interpolateProps (
    input logic               clk,
    input logic               reset,
    input logic               clkEn,
    input logic               cs,
    input interpPkg::busDataT dout,
    input logic               test,
    input interpPkg::sampleT  testValue,
    input interpPkg::sampleT  dataOut,
    input logic               cicClear
);

    int failCount = 0;                        // number of failed assertions so far

    doutIdle: assert property (@(posedge clk) !cs |-> dout == '0)
        else begin
            failCount++;
            $error("dout is not zero while cs is low");
        end

    testFollow: assert property (@(posedge clk) disable iff (reset)
        test |=> dataOut == $past(testValue))
        else begin
            failCount++;
            $error("dataOut missed the test value");
        end

    // the clear pulse ends at the clkEn edge after it started
    clearShort: assert property (@(posedge clk) disable iff (reset)
        (clkEn && cicClear) |=> !cicClear)
        else begin
            failCount++;
            $error("integrator clear held past one input period");
        end

endmodule

bind interpolate interpolateProps props (
    .clk(clk), .reset(reset), .clkEn(clkEn), .cs(cs), .dout(dout),
    .test(ctrl.test), .testValue(ctrl.testValue),
    .dataOut(dataOut), .cicClear(cicClear)
);

// File: test/interpolateTb.sv
`timescale 1ns/1ps

module interpolateTb;

    localparam int modeTest = 0;
    localparam int modeBypass = 1;
    localparam int modeFilter = 2;
    localparam int modeRelease = 3;
    localparam int numRows = 12;
    localparam int readIters = 8;
    localparam int cycleLimit = numRows * 300 + 200;

    // the DC rows from row 5 on use these samples, exponents and mantissas
    localparam int dcSample [7] = '{1000, 1000, -5000, 20000, -300, 7000, 3000};
    localparam int dcExp [7]    = '{4, 4, 5, 6, 2, 8, 4};
    localparam int dcMant [7]   = '{131072, 131072, 98304, 65536, 200000, 262143, 131072};

    typedef struct packed {
        logic [1:0]         mode;
        interpPkg::busDataT ctrlWord;
        interpPkg::busDataT gainWord;
        interpPkg::sampleT  sample;
        interpPkg::sampleT  expected;
    } rowT;

    logic clk, reset, clkEn, cs, wr0, wr1, wr2, wr3;
    interpPkg::busAddrT addr;
    interpPkg::busDataT din, dout, readVal;
    interpPkg::sampleT  dataIn, dataOut;
    logic [1:0]  enCnt;
    logic [31:0] rngState;
    int          cycles;
    rowT         rows [numRows];
    interpPkg::busDataT model [3];

    interpolate i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        enCnt <= enCnt + 2'd1;
        clkEn <= (enCnt == 2'd3);                      // one strobe every four clocks
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout: the run went past %0d clock cycles", cycleLimit);
            $display("Test failures found");
            $fatal(1, "simulation stopped by the cycle limit");
        end
        if (i_dut.props.failCount != 0) begin
            $display("an assertion in the bound property checker failed");
            $display("Test failures found");
            $fatal(1, "stopping on a failed assertion");
        end
    end

    function automatic logic [31:0] xorshift();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // the DC rule scales by 16, keeps 18 bits from bit e and applies the Q1.17 mantissa
    function automatic interpPkg::sampleT dcValue(input interpPkg::sampleT x,
            input int e, input int m, input logic inv);
        longint word;
        logic signed [17:0] win;
        longint prod;
        interpPkg::sampleT r;
        word = longint'(x) * interpPkg::cicGrowth;
        word = word >>> e;
        win = word[17:0];
        prod = longint'(win) * longint'(m);
        r = prod[34:17];
        return inv ? -r : r;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping on the first mismatch");
        end
    endtask

    task automatic busWrite(input interpPkg::busAddrT a, input interpPkg::busDataT d,
            input logic [3:0] lanes);
        @(posedge clk);
        cs <= 1'b1;
        addr <= a;
        din <= d;
        {wr3, wr2, wr1, wr0} <= lanes;
        @(posedge clk);                                // write lands on this edge
        cs <= 1'b0;
        {wr3, wr2, wr1, wr0} <= 4'b0000;
    endtask

    task automatic busRead(input interpPkg::busAddrT a, output interpPkg::busDataT d);
        @(posedge clk);
        cs <= 1'b1;
        addr <= a;
        @(negedge clk);
        d = dout;
        @(posedge clk);
        cs <= 1'b0;
    endtask

    task automatic waitSamples(input int n);
        int k;
        k = 0;
        while (k < n) begin
            @(negedge clk);
            if (clkEn) k++;
        end
        @(posedge clk);
    endtask

    task automatic applyRow(input rowT r);
        busWrite(interpPkg::gainAddr, r.gainWord, 4'hf);
        if (r.mode == modeTest) busWrite(interpPkg::testAddr, 32'(r.expected) & 32'h3ffff, 4'hf);
        if (r.mode == modeRelease) busWrite(interpPkg::ctrlAddr, 32'h1, 4'hf);
        @(posedge clk);
        dataIn <= r.sample;
        if (r.mode == modeRelease) waitSamples(4);
        busWrite(interpPkg::ctrlAddr, r.ctrlWord, 4'hf);
        if (r.mode == modeBypass) waitSamples(1);
        else if (r.mode != modeTest) waitSamples(64);  // filter settles well within this
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("dataOut", dataOut, r.expected);
    endtask

    initial begin
        interpPkg::sampleT x;
        int e, m, idx;
        logic inv;
        logic [31:0] d;
        logic [3:0] lanes;
        rngState = 32'd83806;
        cycles = 0;
        enCnt = '0;
        clkEn = 1'b0;
        {cs, wr0, wr1, wr2, wr3} = '0;
        addr = '0;
        din = '0;
        dataIn = '0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < numRows; i++) begin
            x = xorshift();
            inv = (i % 2 == 1);
            rows[i] = '{modeFilter, 32'(inv) << 2, 32'h0, x, '0};
            if (i < 2) begin
                rows[i].mode = modeTest;
                rows[i].ctrlWord = 32'h2 | (xorshift() & 32'h5);  // bypass and invert ignored
                rows[i].expected = xorshift();
            end else if (i < 5) begin
                rows[i].mode = modeBypass;
                rows[i].ctrlWord |= 32'h1;
                rows[i].expected = inv ? -x : x;
            end else begin
                x = dcSample[i-5];
                e = dcExp[i-5];
                m = dcMant[i-5];
                if (i == numRows - 1) rows[i].mode = modeRelease;
                rows[i].sample = x;
                rows[i].gainWord = (32'(e) << 24) | 32'(m);
                rows[i].expected = dcValue(x, e, m, inv);
            end
        end

        for (int a = 0; a < 3; a++) begin
            busRead(a, readVal);
            check("dout after reset", readVal, 32'h0);
            model[a] = '0;
        end
        for (int i = 0; i < readIters; i++) begin
            idx = xorshift() % 3;
            d = xorshift();
            lanes = xorshift();
            busWrite(idx, d, lanes);
            for (int b = 0; b < 4; b++) begin
                if (lanes[b]) model[idx][8*b +: 8] = d[8*b +: 8];
            end
            model[idx] &= (idx == 0) ? 32'h7 : (idx == 1) ? 32'h3ffff : 32'h1f03ffff;
            busRead(idx, readVal);
            check("dout", readVal, model[idx]);
        end

        for (int i = 0; i < numRows; i++) begin
            applyRow(rows[i]);
        end

        if (i_dut.props.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: interpolate.f
design/interpPkg.sv
design/interpRegs.sv
design/cicComp.sv
design/cicInterpolate.sv
design/gainScale.sv
design/interpolate.sv
test/interpolate_props.sv
test/interpolateTb.sv

// File: Bender.yml
package:
  name: interpolate

sources:
  - files:
      - design/interpPkg.sv
      - design/interpRegs.sv
      - design/cicComp.sv
      - design/cicInterpolate.sv
      - design/gainScale.sv
      - design/interpolate.sv
  - target: test
    files:
      - test/interpolate_props.sv
      - test/interpolateTb.sv
